//--- sim.f
+incdir+hdl
hdl/icache_pkg.sv
hdl/icache_fill_if.sv
hdl/icache_arrays.sv
hdl/icache_lookup.sv
hdl/icache_mshr.sv
hdl/icache_top.sv
dv/icache_mem_model.sv
dv/icache_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build the icache testbench with Verilator, run it and look for the pass message

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -j 0 \
  --top-module icache_tb -f sim.f -o icache_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

output=$(./obj_dir/icache_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "Verification passed"; then
  exit 0
fi
exit 1

//--- dv/icache_tb.sv
/* testbench for the instruction cache controller
   drives fetch, memory and scratchpad traffic, concurrent assertions check the cache */
`timescale 1ns/1ps
`default_nettype none

`include "icache_macros.svh"

module icache_tb
  import icache_pkg::*;
();

  // all tests together take a few hundred cycles, the limit leaves a wide margin
  localparam int TIMEOUT_CYCLES = 4000;
  // replays allowed before a fetch counts as stuck
  localparam int HIT_WAIT_CYCLES = 40;

  logic clk;
  logic reset;

  // dut ports
  logic          fetch_req;
  pc_t           pc;
  inst_t         inst [`ICACHE_FETCH_WIDTH];
  logic [`ICACHE_FETCH_WIDTH-1:0] inst_valid;
  block_addr_t   mem_req_addr;
  logic          mem_req_valid;
  tag_t          mem_resp_tag;
  index_t        mem_resp_index;
  line_t         mem_resp_data;
  logic          mem_resp_valid;
  logic          scratch_mode;
  logic          scratch_wr_en;
  scratch_addr_t scratch_addr;
  byte_t         scratch_wr_data;
  byte_t         scratch_rd_data;
  int            outstanding;

  // checker enables, driven along with the stimulus
  logic idle_check;
  logic first_fetch;
  logic rd_check;
  logic scratch_fetch_check;
  // scratch mode as the cache sees it, after its input register
  logic scratch_q;

  // mirror of the bytes written through the scratch port
  byte_t smem [256];

  int   errors;
  int   test_err_start;
  int   tests_run;
  int   tests_failed;
  int   cycles;
  pc_t  base_pc;

  icache_top icache_top_inst (
    .clk               (clk),
    .reset             (reset),
    .fetch_req_i       (fetch_req),
    .pc_i              (pc),
    .inst_o            (inst),
    .inst_valid_o      (inst_valid),
    .mem_req_addr_o    (mem_req_addr),
    .mem_req_valid_o   (mem_req_valid),
    .mem_resp_tag_i    (mem_resp_tag),
    .mem_resp_index_i  (mem_resp_index),
    .mem_resp_data_i   (mem_resp_data),
    .mem_resp_valid_i  (mem_resp_valid),
    .scratch_mode_i    (scratch_mode),
    .scratch_wr_en_i   (scratch_wr_en),
    .scratch_addr_i    (scratch_addr),
    .scratch_wr_data_i (scratch_wr_data),
    .scratch_rd_data_o (scratch_rd_data)
  );

  icache_mem_model mem_model (
    .clk              (clk),
    .reset            (reset),
    .mem_req_valid_i  (mem_req_valid),
    .mem_req_addr_i   (mem_req_addr),
    .mem_resp_valid_o (mem_resp_valid),
    .mem_resp_tag_o   (mem_resp_tag),
    .mem_resp_index_o (mem_resp_index),
    .mem_resp_data_o  (mem_resp_data),
    .outstanding_o    (outstanding)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES)
    begin
      $display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Verification failed");
      $finish;
    end
  end

  always @(posedge clk or posedge reset)
  begin
    if (reset)
      scratch_q <= 1'b0;
    else
      scratch_q <= scratch_mode;
  end

  ////////////////////////////////////////////////////////////
  // expected values
  // word w of a memory line is the block address with w in the two low bits
  function automatic inst_t expect_word(input pc_t addr, input int slot);
    logic [1:0] w;
    begin
      w = addr[3:2] + 2'(slot);
      return inst_t'({addr[31:4], w});
    end
  endfunction

  // little endian, byte 4w of the line sits in the low bits of word w
  function automatic inst_t scratch_word(input pc_t addr, input int slot);
    logic [1:0] w;
    logic [5:0] word_addr;
    begin
      w = addr[3:2] + 2'(slot);
      word_addr = {addr[7:4], w};
      return {smem[{word_addr, 2'd3}], smem[{word_addr, 2'd2}],
              smem[{word_addr, 2'd1}], smem[{word_addr, 2'd0}]};
    end
  endfunction

  ////////////////////////////////////////////////////////////
  // stimulus helpers
  task automatic report_fail(input string msg);
    begin
      errors++;
      $display("[FAIL] %0t ns: %s", $time, msg);
    end
  endtask

  task automatic next_cycle();
    begin
      @(posedge clk);
      #1;
    end
  endtask

  // replay the fetch until it hits, outputs are looked at on the falling edge
  task automatic fetch_until_hit(input pc_t addr, input logic cold);
    int waited;
    begin
      waited = 0;
      fetch_req = 1'b1;
      pc = addr;
      first_fetch = cold;
      @(negedge clk);
      while (!inst_valid[0] && waited < HIT_WAIT_CYCLES)
      begin
        next_cycle();
        first_fetch = 1'b0;
        @(negedge clk);
        waited++;
      end
      if (!inst_valid[0])
      begin
        errors++;
        $display("fetch of pc %h got no hit within %0d cycles", addr, HIT_WAIT_CYCLES);
      end
      next_cycle();
      fetch_req = 1'b0;
      first_fetch = 1'b0;
    end
  endtask

  task automatic scratch_write(input scratch_addr_t addr, input byte_t data);
    begin
      scratch_wr_en = 1'b1;
      scratch_addr = addr;
      scratch_wr_data = data;
      smem[addr] = data;
      next_cycle();
      scratch_wr_en = 1'b0;
    end
  endtask

  task automatic scratch_read(input scratch_addr_t addr);
    begin
      scratch_addr = addr;
      rd_check = 1'b1;
      next_cycle();
      rd_check = 1'b0;
    end
  endtask

  task automatic finish_test(input string name);
    begin
      tests_run++;
      if (errors == test_err_start)
        $display("test %0d %s: ok", tests_run, name);
      else
      begin
        tests_failed++;
        $display("test %0d %s: %0d errors", tests_run, name, errors - test_err_start);
      end
      test_err_start = errors;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // checkers
  a_idle_quiet: assert property (
    @(posedge clk) disable iff (reset)
    idle_check |-> (!mem_req_valid && inst_valid == '0)
  ) else report_fail("request or instruction valid while no fetch is made");

  a_valid_needs_fetch: assert property (
    @(posedge clk) disable iff (reset)
    !fetch_req |-> (inst_valid == '0)
  ) else report_fail("instruction valid without a fetch");

  // cold miss goes to memory exactly one cycle after the fetch cycle
  a_req_timing: assert property (
    @(posedge clk) disable iff (reset)
    first_fetch |-> !mem_req_valid ##1 (mem_req_valid && mem_req_addr == pc[31:4])
  ) else report_fail("miss request late, early or with the wrong block address");

  // held fetch hits two cycles after its own response
  a_fill_to_hit: assert property (
    @(posedge clk) disable iff (reset)
    (mem_resp_valid && fetch_req && !scratch_q
     && {mem_resp_tag, mem_resp_index} == pc[31:4])
    |-> ##1 !inst_valid[0] ##1 inst_valid[0]
  ) else report_fail("held fetch did not hit exactly 2 cycles after the response");

  a_hit_data: assert property (
    @(posedge clk) disable iff (reset)
    (inst_valid[0] && !scratch_q) |->
      (inst[0] == expect_word(pc, 0)) && (inst_valid[1] == (pc[3:2] != 2'd3))
      && (inst[1] == ((pc[3:2] != 2'd3) ? expect_word(pc, 1) : '0))
  ) else report_fail("cache hit returned wrong instructions or slot valids");

  a_single_request: assert property (
    @(posedge clk) disable iff (reset)
    mem_req_valid |-> (outstanding == 0)
  ) else report_fail("request raised while another one is outstanding");

  a_outstanding_max: assert property (
    @(posedge clk) disable iff (reset)
    outstanding <= 1
  ) else report_fail("more than one request outstanding");

  // scratch read shows the byte at the address of the cycle before
  a_scratch_read: assert property (
    @(posedge clk) disable iff (reset)
    rd_check |=> (scratch_rd_data == smem[$past(scratch_addr)])
  ) else report_fail("scratch read returned the wrong byte");

  a_scratch_hit: assert property (
    @(posedge clk) disable iff (reset)
    (scratch_q && fetch_req) |-> inst_valid[0]
  ) else report_fail("fetch missed in scratch mode");

  a_scratch_fetch: assert property (
    @(posedge clk) disable iff (reset)
    (scratch_fetch_check && fetch_req) |->
      (inst[0] == scratch_word(pc, 0)) && (inst_valid[1] == (pc[3:2] != 2'd3))
      && (!inst_valid[1] || inst[1] == scratch_word(pc, 1))
  ) else report_fail("scratch fetch returned bytes that were not written");

  ////////////////////////////////////////////////////////////
  // test sequence
  initial
  begin
    void'($urandom(18));
    reset = 1'b1;
    fetch_req = 1'b0;
    pc = '0;
    scratch_mode = 1'b0;
    scratch_wr_en = 1'b0;
    scratch_addr = '0;
    scratch_wr_data = '0;
    idle_check = 1'b1;
    first_fetch = 1'b0;
    rd_check = 1'b0;
    scratch_fetch_check = 1'b0;
    errors = 0;
    test_err_start = 0;
    tests_run = 0;
    tests_failed = 0;
    cycles = 0;
    repeat (16) @(posedge clk);
    #1;
    reset = 1'b0;

    // quiet after reset, then one cold miss
    repeat (4) next_cycle();
    idle_check = 1'b0;
    fetch_until_hit(32'h1000_0010, 1'b1);
    finish_test("cold miss request");

    // second line at offset 1, then both lines hit at once
    fetch_until_hit(32'h2000_0064, 1'b1);
    fetch_until_hit(32'h1000_0010, 1'b0);
    fetch_until_hit(32'h2000_0068, 1'b0);
    finish_test("fill then hit");

    // random lines walked through every offset
    repeat (6)
    begin
      base_pc = $urandom() & 32'hFFFF_FFF0;
      for (int off = 0; off < 4; off++)
        fetch_until_hit(base_pc | (pc_t'(off) << 2), off == 0);
    end
    finish_test("slot valids");

    // B misses while A is outstanding, its request waits for A's fill
    fetch_req = 1'b1;
    pc = 32'h0012_3440;
    first_fetch = 1'b1;
    next_cycle();
    first_fetch = 1'b0;
    next_cycle();
    fetch_until_hit(32'h0045_6780, 1'b0);
    fetch_until_hit(32'h0012_3440, 1'b0);
    finish_test("miss under busy mshr");

    // scratch mode comes on while a miss to line 9 goes out
    scratch_mode = 1'b1;
    fetch_req = 1'b1;
    pc = 32'h5A5A_5A90;
    first_fetch = 1'b1;
    next_cycle();
    first_fetch = 1'b0;
    fetch_req = 1'b0;
    // the response lands during these writes and must be dropped
    for (int b = 0; b < 16; b++)
      scratch_write({4'd9, 4'(b)}, byte_t'($urandom()));
    for (int b = 0; b < 16; b++)
      scratch_write({4'd3, 4'(b)}, byte_t'($urandom()));
    next_cycle();
    for (int b = 0; b < 16; b++)
      scratch_read({4'd9, 4'(b)});
    for (int b = 0; b < 16; b++)
      scratch_read({4'd3, 4'(b)});
    scratch_fetch_check = 1'b1;
    for (int off = 0; off < 4; off++)
    begin
      fetch_until_hit(32'h0000_0090 | (pc_t'(off) << 2), 1'b0);
      fetch_until_hit(32'h7700_0030 | (pc_t'(off) << 2), 1'b0);
    end
    scratch_fetch_check = 1'b0;
    repeat (3) next_cycle();
    finish_test("scratchpad");

    $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- dv/icache_mem_model.sv
/* fixed-latency memory responder for the icache testbench
   answers each request 3 cycles later with a line built from its block address */
`timescale 1ns/1ps
`default_nettype none

module icache_mem_model
  import icache_pkg::*;
(
  input  wire         clk,
  input  wire         reset,
  input  logic        mem_req_valid_i,
  input  block_addr_t mem_req_addr_i,
  output logic        mem_resp_valid_o,
  output tag_t        mem_resp_tag_o,
  output index_t      mem_resp_index_o,
  output line_t       mem_resp_data_o,
  output int          outstanding_o
);

  localparam int LATENCY = 3;

  // request delay line, the last stage is on the response bus
  logic        pipe_valid [LATENCY];
  block_addr_t pipe_addr  [LATENCY];

  // word k carries the block address with k in the two low bits
  function automatic line_t pattern_line(input block_addr_t addr);
    line_t data;
    begin
      for (int k = 0; k < 4; k++)
        data[k*32 +: 32] = inst_t'({addr, 2'(k)});
      return data;
    end
  endfunction

  always @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      for (int i = 0; i < LATENCY; i++)
      begin
        pipe_valid[i] <= 1'b0;
        pipe_addr[i]  <= '0;
      end
      outstanding_o <= 0;
    end
    else
    begin
      pipe_valid[0] <= mem_req_valid_i;
      pipe_addr[0]  <= mem_req_addr_i;
      for (int i = 1; i < LATENCY; i++)
      begin
        pipe_valid[i] <= pipe_valid[i-1];
        pipe_addr[i]  <= pipe_addr[i-1];
      end
      // a response on the bus retires its request at the end of the cycle
      outstanding_o <= outstanding_o + int'(mem_req_valid_i) - int'(pipe_valid[LATENCY-1]);
    end
  end

  // response bus changes 1 ns after the edge, like the rest of the stimulus
  initial
  begin
    mem_resp_valid_o = 1'b0;
    mem_resp_tag_o   = '0;
    mem_resp_index_o = '0;
    mem_resp_data_o  = '0;
    forever
    begin
      @(posedge clk);
      #1;
      mem_resp_valid_o = pipe_valid[LATENCY-1];
      {mem_resp_tag_o, mem_resp_index_o} = pipe_addr[LATENCY-1];
      mem_resp_data_o  = pattern_line(pipe_addr[LATENCY-1]);
    end
  end

endmodule

`default_nettype wire

//--- hdl/icache_top.sv
/* instruction cache controller top, fetch port, memory port and scratchpad port
   storage, lookup and miss handler joined by the fill interface */
`timescale 1ns/1ps
`default_nettype none

`include "icache_macros.svh"

module icache_top
  import icache_pkg::*;
(
  input  wire           clk,
  input  wire           reset,
  // fetch stage
  input  logic          fetch_req_i,
  input  pc_t           pc_i,
  output inst_t         inst_o [`ICACHE_FETCH_WIDTH],
  output logic [`ICACHE_FETCH_WIDTH-1:0] inst_valid_o,
  // memory
  output block_addr_t   mem_req_addr_o,
  output logic          mem_req_valid_o,
  input  tag_t          mem_resp_tag_i,
  input  index_t        mem_resp_index_i,
  input  line_t         mem_resp_data_i,
  input  logic          mem_resp_valid_i,
  // scratchpad
  input  logic          scratch_mode_i,
  input  logic          scratch_wr_en_i,
  input  scratch_addr_t scratch_addr_i,
  input  byte_t         scratch_wr_data_i,
  output byte_t         scratch_rd_data_o
);

  // array read path and control between the blocks
  index_t rd_index;
  tag_t   rd_tag;
  logic   rd_valid;
  line_t  rd_line;
  logic   scratch_mode;
  logic   miss;

  icache_fill_if fill_if ();

  icache_arrays icache_arrays_inst (
    .clk               (clk),
    .reset             (reset),
    .scratch_mode_i    (scratch_mode_i),
    .scratch_wr_en_i   (scratch_wr_en_i),
    .scratch_addr_i    (scratch_addr_i),
    .scratch_wr_data_i (scratch_wr_data_i),
    .rd_index_i        (rd_index),
    .fill              (fill_if.arrays),
    .scratch_mode_o    (scratch_mode),
    .scratch_rd_data_o (scratch_rd_data_o),
    .rd_tag_o          (rd_tag),
    .rd_valid_o        (rd_valid),
    .rd_line_o         (rd_line)
  );

  icache_lookup icache_lookup_inst (
    .fetch_req_i    (fetch_req_i),
    .pc_i           (pc_i),
    .scratch_mode_i (scratch_mode),
    .rd_tag_i       (rd_tag),
    .rd_valid_i     (rd_valid),
    .rd_line_i      (rd_line),
    .rd_index_o     (rd_index),
    .miss_o         (miss),
    .inst_o         (inst_o),
    .inst_valid_o   (inst_valid_o)
  );

  icache_mshr icache_mshr_inst (
    .clk              (clk),
    .reset            (reset),
    .pc_i             (pc_i),
    .miss_i           (miss),
    .scratch_mode_i   (scratch_mode),
    .mem_resp_tag_i   (mem_resp_tag_i),
    .mem_resp_index_i (mem_resp_index_i),
    .mem_resp_data_i  (mem_resp_data_i),
    .mem_resp_valid_i (mem_resp_valid_i),
    .mem_req_addr_o   (mem_req_addr_o),
    .mem_req_valid_o  (mem_req_valid_o),
    .fill             (fill_if.mshr)
  );

endmodule

`default_nettype wire

//--- hdl/icache_mshr.sv
/* single outstanding miss, memory request pulse and fill register
   one request per miss, and a held fetch asks again after the current fill */
`timescale 1ns/1ps
`default_nettype none

module icache_mshr
  import icache_pkg::*;
(
  input  wire         clk,
  input  wire         reset,
  input  pc_t         pc_i,
  input  logic        miss_i,
  input  logic        scratch_mode_i,
  input  tag_t        mem_resp_tag_i,
  input  index_t      mem_resp_index_i,
  input  line_t       mem_resp_data_i,
  input  logic        mem_resp_valid_i,
  output block_addr_t mem_req_addr_o,
  output logic        mem_req_valid_o,
  icache_fill_if.mshr fill
);

  // pc fields of the fetch cycle for the request in the next cycle
  tag_t   pc_tag_q;
  index_t pc_index_q;

  // miss history for the single-shot pulse
  logic miss_d1;
  logic miss_d2;
  logic miss_pulse;

  // the one mshr
  logic   mshr_busy;
  tag_t   mshr_tag;
  index_t mshr_index;
  logic   resp_match;

  always_ff @(posedge clk)
  begin
    pc_tag_q   <= pc_i[$bits(pc_t)-1 -: $bits(tag_t)];
    pc_index_q <= pc_i[$bits(pc_t)-$bits(tag_t)-1 -: $bits(index_t)];
  end

  ////////////////////////////////////////////////////////////
  // request pulse
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      miss_d1 <= 1'b0;
      miss_d2 <= 1'b0;
    end
    else
    begin
      // cleared by a fill so a still pending miss pulses again
      miss_d1 <= miss_i && !fill.fill_valid;
      miss_d2 <= miss_d1;
    end
  end

  assign miss_pulse = miss_d1 && !miss_d2;

  // only when free, or freed by a fill in this same cycle
  assign mem_req_valid_o = miss_pulse && (!mshr_busy || fill.fill_valid);
  assign mem_req_addr_o  = {pc_tag_q, pc_index_q};

  ////////////////////////////////////////////////////////////
  // mshr state
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      mshr_busy <= 1'b0;
    else if (mem_req_valid_o)
      mshr_busy <= 1'b1;
    else if (fill.fill_valid)
      mshr_busy <= 1'b0;
  end

  always_ff @(posedge clk)
  begin
    if (mem_req_valid_o)
    begin
      mshr_tag   <= pc_tag_q;
      mshr_index <= pc_index_q;
    end
  end

  ////////////////////////////////////////////////////////////
  // fill register
  assign resp_match = mem_resp_valid_i && mshr_busy
                      && (mem_resp_tag_i == mshr_tag) && (mem_resp_index_i == mshr_index);

  // nothing is filled in scratch mode
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      fill.fill_valid <= 1'b0;
    else
      fill.fill_valid <= resp_match && !scratch_mode_i;
  end

  always_ff @(posedge clk)
  begin
    fill.fill_index <= mshr_index;
    fill.fill_tag   <= mshr_tag;
    fill.fill_data  <= mem_resp_data_i;
  end

  a_req_needs_free_mshr: assert property (
    @(posedge clk) disable iff (reset)
    (mem_req_valid_o && mshr_busy) |-> fill.fill_valid
  ) else $error("request raised while the mshr is busy");

endmodule

`default_nettype wire

//--- hdl/icache_lookup.sv
/* hit detection and fetch slot extraction in the fetch cycle
   purely combinational, reads the arrays at the index taken from the pc */
`timescale 1ns/1ps
`default_nettype none

`include "icache_macros.svh"

module icache_lookup
  import icache_pkg::*;
(
  input  logic   fetch_req_i,
  input  pc_t    pc_i,
  input  logic   scratch_mode_i,
  input  tag_t   rd_tag_i,
  input  logic   rd_valid_i,
  input  line_t  rd_line_i,
  output index_t rd_index_o,
  output logic   miss_o,
  output inst_t  inst_o [`ICACHE_FETCH_WIDTH],
  output logic [`ICACHE_FETCH_WIDTH-1:0] inst_valid_o
);

  // pc fields
  offset_t pc_offset;
  index_t  pc_index;
  tag_t    pc_tag;
  logic    hit;

  // word position per slot, one extra bit to see the end of the line
  logic [`ICACHE_OFFSET_BITS:0] word_sel [`ICACHE_FETCH_WIDTH];

  assign pc_offset = pc_i[`ICACHE_INST_BYTE_LOG +: `ICACHE_OFFSET_BITS];
  assign pc_index  = pc_i[`ICACHE_INST_BYTE_LOG+`ICACHE_OFFSET_BITS +: `ICACHE_INDEX_BITS];
  assign pc_tag    = pc_i[`ICACHE_PC_BITS-1 -: `ICACHE_TAG_BITS];

  assign rd_index_o = pc_index;

  // scratch mode hits on every fetch
  // no bypass from the fill, the fetch unit replays until the line is in
  assign hit    = scratch_mode_i ? fetch_req_i
                                 : fetch_req_i && rd_valid_i && (rd_tag_i == pc_tag);
  assign miss_o = fetch_req_i && !hit;

  ////////////////////////////////////////////////////////////
  // slots k take word offset+k, nothing past the end of the line
  always_comb
  begin
    for (int k = 0; k < `ICACHE_FETCH_WIDTH; k++)
    begin
      word_sel[k] = {1'b0, pc_offset} + (`ICACHE_OFFSET_BITS+1)'(k);
      if (word_sel[k] < `ICACHE_INSTS_PER_LINE)
      begin
        inst_valid_o[k] = hit;
        inst_o[k] = rd_line_i[word_sel[k][`ICACHE_OFFSET_BITS-1:0]*`ICACHE_INST_BITS
                              +: `ICACHE_INST_BITS];
      end
      else
      begin
        inst_valid_o[k] = 1'b0;
        inst_o[k]       = '0;
      end
    end
  end

  // slot 0 never runs past the line, so it tracks the hit exactly
  always_comb
  begin
    a_slot0_is_hit: assert (inst_valid_o[0] == (fetch_req_i && !miss_o))
      else $error("slot 0 valid disagrees with hit");
  end

endmodule

`default_nettype wire

//--- hdl/icache_arrays.sv
/* data, tag and valid storage of the direct-mapped cache
   combinational read for lookup, fill write, and the scratchpad byte port */
`timescale 1ns/1ps
`default_nettype none

`include "icache_macros.svh"

module icache_arrays
  import icache_pkg::*;
(
  input  wire           clk,
  input  wire           reset,
  input  logic          scratch_mode_i,
  input  logic          scratch_wr_en_i,
  input  scratch_addr_t scratch_addr_i,
  input  byte_t         scratch_wr_data_i,
  input  index_t        rd_index_i,
  icache_fill_if.arrays fill,
  output logic          scratch_mode_o,
  output byte_t         scratch_rd_data_o,
  output tag_t          rd_tag_o,
  output logic          rd_valid_o,
  output line_t         rd_line_o
);

  // storage
  line_t                         data_array [`ICACHE_NUM_LINES];
  tag_t                          tag_array  [`ICACHE_NUM_LINES];
  logic [`ICACHE_NUM_LINES-1:0]  valid_array;

  // scratch inputs, one register stage for timing and fanout
  logic      scratch_mode_q;
  logic      scratch_wr_en_q;
  index_t    scratch_index_q;
  byte_sel_t scratch_byte_q;
  byte_t     scratch_data_q;

  ////////////////////////////////////////////////////////////
  // scratch register stage
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      // cache mode after reset
      scratch_mode_q  <= 1'b0;
      scratch_wr_en_q <= 1'b0;
      scratch_index_q <= '0;
      scratch_byte_q  <= '0;
    end
    else
    begin
      scratch_mode_q  <= scratch_mode_i;
      scratch_wr_en_q <= scratch_wr_en_i;
      scratch_index_q <= scratch_addr_i[`ICACHE_INDEX_BITS+`ICACHE_LINE_BYTES_LOG-1:
                                        `ICACHE_LINE_BYTES_LOG];
      scratch_byte_q  <= scratch_addr_i[`ICACHE_LINE_BYTES_LOG-1:0];
    end
  end

  // write data follows the enable
  always_ff @(posedge clk)
  begin
    scratch_data_q <= scratch_wr_data_i;
  end

  assign scratch_mode_o = scratch_mode_q;

  ////////////////////////////////////////////////////////////
  // writes, a fill wins over a scratch byte
  always_ff @(posedge clk)
  begin
    if (fill.fill_valid)
    begin
      data_array[fill.fill_index] <= fill.fill_data;
      tag_array[fill.fill_index]  <= fill.fill_tag;
    end
    else if (scratch_wr_en_q && scratch_mode_q)
    begin
      data_array[scratch_index_q][scratch_byte_q*8 +: 8] <= scratch_data_q;
    end
  end

  // line becomes valid together with the fill write
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      valid_array <= '0;
    else if (fill.fill_valid)
      valid_array[fill.fill_index] <= 1'b1;
  end

  ////////////////////////////////////////////////////////////
  // reads
  // lookup read at the unregistered pc index
  assign rd_line_o  = data_array[rd_index_i];
  assign rd_tag_o   = tag_array[rd_index_i];
  assign rd_valid_o = valid_array[rd_index_i];

  // scratch read shows the byte at the registered address
  assign scratch_rd_data_o = data_array[scratch_index_q][scratch_byte_q*8 +: 8];

  // the miss handler suppresses fills in scratch mode, so no byte write gets lost
  a_no_fill_on_scratch_wr: assert property (
    @(posedge clk) disable iff (reset)
    (scratch_wr_en_q && scratch_mode_q) |-> !fill.fill_valid
  ) else $error("scratch write collides with a line fill");

endmodule

`default_nettype wire

//--- hdl/icache_fill_if.sv
/* line fill from the miss handler into the storage arrays
   fill_valid is a one-cycle strobe, the other fields are valid with it */
`timescale 1ns/1ps
`default_nettype none

interface icache_fill_if
  import icache_pkg::*;
();

  logic   fill_valid;
  index_t fill_index;
  tag_t   fill_tag;
  line_t  fill_data;

  // miss handler side, registers the returned line
  modport mshr (
    output fill_valid, fill_index, fill_tag, fill_data
  );

  // storage side, writes the line at fill_index
  modport arrays (
    input fill_valid, fill_index, fill_tag, fill_data
  );

endinterface

`default_nettype wire

//--- hdl/icache_pkg.sv
/* field types shared by the instruction cache modules
   imported by wildcard in each module header */
`default_nettype none

`include "icache_macros.svh"

package icache_pkg;

  // fetch side
  typedef logic [`ICACHE_PC_BITS-1:0]   pc_t;
  typedef logic [`ICACHE_INST_BITS-1:0] inst_t;

  // one whole cache line, word 0 in the low bits
  typedef logic [`ICACHE_LINE_BITS-1:0] line_t;

  ////////////////////////////////////////////////////////////
  // pc fields
  typedef logic [`ICACHE_TAG_BITS-1:0]    tag_t;
  typedef logic [`ICACHE_INDEX_BITS-1:0]  index_t;
  typedef logic [`ICACHE_OFFSET_BITS-1:0] offset_t;

  // tag then index, the address sent to memory on a miss
  typedef logic [`ICACHE_TAG_BITS+`ICACHE_INDEX_BITS-1:0] block_addr_t;

  ////////////////////////////////////////////////////////////
  // scratchpad port
  typedef logic [`ICACHE_LINE_BYTES_LOG-1:0] byte_sel_t;
  // index in the upper bits, byte select in the lower bits
  typedef logic [`ICACHE_INDEX_BITS+`ICACHE_LINE_BYTES_LOG-1:0] scratch_addr_t;
  typedef logic [7:0] byte_t;

endpackage

`default_nettype wire

//--- hdl/icache_macros.svh
/* geometry of the instruction cache and the fetch port
   included by the package and by every module that sizes a loop or an array */
`ifndef ICACHE_MACROS_SVH
`define ICACHE_MACROS_SVH

// fetch address and instruction word
`define ICACHE_PC_BITS        32
`define ICACHE_INST_BITS      32
// pc bits below the instruction word
`define ICACHE_INST_BYTE_LOG  2

// line geometry, 4 words of 32 bits per line
`define ICACHE_OFFSET_BITS    2
`define ICACHE_INSTS_PER_LINE 4
`define ICACHE_INDEX_BITS     4
`define ICACHE_NUM_LINES      16
`define ICACHE_TAG_BITS       24
`define ICACHE_LINE_BITS      128
// byte select inside one line, used by the scratch port
`define ICACHE_LINE_BYTES_LOG 4

// instructions handed to the fetch stage per cycle
`define ICACHE_FETCH_WIDTH    2

`endif
